// ==== src/sched_config.svh ====
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

`define SCHED_IF_COUNT     2
`define SCHED_CORE_COUNT   4
`define SCHED_SLOT_COUNT   8
`define SCHED_DATA_WIDTH   32
`define SCHED_HOST_WIDTH   32

// Host command address field, bits 29 to 27
`define SCHED_ADDR_INCOME  3'd0
`define SCHED_ADDR_ENABLE  3'd1
`define SCHED_ADDR_COUNT   3'd2
`define SCHED_ADDR_FLUSH   3'd3
`define SCHED_ADDR_DEST    3'd4
`define SCHED_ADDR_INTS    3'd5
`define SCHED_ADDR_RELEASE 3'd6

// Slot message types
`define SCHED_MSG_RETURN   2'd0
`define SCHED_MSG_INIT     2'd3

`define SCHED_BAD_READ     32'hFEFEFEFE

`endif

// ==== src/sched_pkg.sv ====
`include "sched_config.svh"

package sched_pkg;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0] core_id_t;
  typedef logic [`SCHED_CORE_COUNT-1:0]         core_mask_t;
  typedef logic [`SCHED_IF_COUNT-1:0]           if_mask_t;
  // Slots run from 1, zero means none
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;
  // Core index above slot number
  typedef logic [$bits(core_id_t)+$bits(slot_t)-1:0] dest_t;
  typedef logic [`SCHED_HOST_WIDTH-1:0] host_word_t;
  typedef logic [`SCHED_DATA_WIDTH-1:0] data_t;

  typedef enum logic [1:0] {
    STALL, // no descriptor held, input blocked
    FIRST, // descriptor held, waiting for a packet
    WAIT,  // packet running, no spare descriptor yet
    MID    // packet running, next descriptor reserved
  } port_state_e;

endpackage

// ==== src/host_cmd_regs.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module host_cmd_regs (
  input  logic                  clk,
  input  logic                  rst_r,
  input  sched_pkg::host_word_t host_cmd,
  input  sched_pkg::host_word_t host_cmd_wr_data,
  input  logic                  host_cmd_valid,
  input  sched_pkg::slot_t      slot_counts [`SCHED_CORE_COUNT],
  input  sched_pkg::dest_t      port_dest [`SCHED_IF_COUNT],
  output sched_pkg::core_mask_t income_cores,
  output sched_pkg::core_mask_t enabled_cores,
  output sched_pkg::if_mask_t   enabled_ints,
  output sched_pkg::core_mask_t slots_flush,
  output sched_pkg::if_mask_t   release_desc,
  output sched_pkg::host_word_t host_cmd_rd_data
);
  import sched_pkg::*;

  localparam int IF_W = $clog2(`SCHED_IF_COUNT);

  logic            sched_wr_r;
  logic [2:0]      addr_r;
  host_word_t      wr_data_r;
  core_id_t        rd_core_r;
  logic [IF_W-1:0] rd_if_r;
  host_word_t      rd_data_n;

  always_ff @(posedge clk) begin
    addr_r    <= host_cmd[29:27];
    wr_data_r <= host_cmd_wr_data;
    rd_core_r <= host_cmd[$bits(core_id_t)-1:0];
    rd_if_r   <= host_cmd[IF_W-1:0];
  end

  // Bit 31 marks a write, bit 30 a scheduler command
  always_ff @(posedge clk) begin
    if (rst_r) begin
      sched_wr_r <= 1'b0;
    end else begin
      sched_wr_r <= host_cmd_valid && host_cmd[31] && host_cmd[30];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      income_cores  <= '0;
      enabled_cores <= '0;
      enabled_ints  <= '0;
      slots_flush   <= '0;
      release_desc  <= '0;
    end else begin
      slots_flush  <= '0;
      release_desc <= '0;
      if (sched_wr_r) begin
        case (addr_r)
          `SCHED_ADDR_INCOME: begin
            income_cores <= wr_data_r[`SCHED_CORE_COUNT-1:0] & enabled_cores;
          end
          `SCHED_ADDR_ENABLE: begin
            // A core that was off cannot stay incoming
            income_cores  <= income_cores & enabled_cores;
            enabled_cores <= wr_data_r[`SCHED_CORE_COUNT-1:0];
          end
          `SCHED_ADDR_FLUSH:   slots_flush  <= wr_data_r[`SCHED_CORE_COUNT-1:0];
          `SCHED_ADDR_INTS:    enabled_ints <= wr_data_r[`SCHED_IF_COUNT-1:0];
          `SCHED_ADDR_RELEASE: release_desc <= wr_data_r[`SCHED_IF_COUNT-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (addr_r)
      `SCHED_ADDR_INCOME: rd_data_n = host_word_t'(income_cores);
      `SCHED_ADDR_ENABLE: rd_data_n = host_word_t'(enabled_cores);
      `SCHED_ADDR_COUNT:  rd_data_n = host_word_t'(slot_counts[rd_core_r]);
      `SCHED_ADDR_DEST:   rd_data_n = host_word_t'(port_dest[rd_if_r]);
      `SCHED_ADDR_INTS:   rd_data_n = host_word_t'(enabled_ints);
      default:            rd_data_n = `SCHED_BAD_READ;
    endcase
  end

  always_ff @(posedge clk) begin
    host_cmd_rd_data <= rd_data_n;
  end

endmodule

// ==== src/slot_keeper.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module slot_keeper (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             flush,
  input  logic             init_valid,
  input  sched_pkg::slot_t init_slots,
  input  logic             slot_in_valid,
  input  sched_pkg::slot_t slot_in,
  input  logic             slot_pop,
  output sched_pkg::slot_t slot_out,
  output logic             slot_out_valid,
  output sched_pkg::slot_t slot_count,
  output logic             enq_err
);
  import sched_pkg::*;

  localparam int DEPTH = `SCHED_SLOT_COUNT;
  localparam int PTR_W = $clog2(DEPTH);

  slot_t            mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full           = slot_count == slot_t'(DEPTH);
  assign slot_out_valid = slot_count != '0;
  assign slot_out       = mem[rd_ptr];
  assign do_pop         = slot_pop && slot_out_valid;
  // A pop in the same cycle frees room for the push
  assign do_push        = slot_in_valid && (!full || do_pop);
  assign enq_err        = slot_in_valid && full && !do_pop;

  // Init lays out every slot number, only the first N are counted
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (do_push) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      slot_count <= '0;
    end else if (init_valid) begin
      rd_ptr     <= '0;
      wr_ptr     <= init_slots[PTR_W-1:0];
      slot_count <= init_slots;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        slot_count <= slot_count + 1'b1;
      end else if (do_pop && !do_push) begin
        slot_count <= slot_count - 1'b1;
      end
    end
  end

endmodule

// ==== src/slot_pool.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module slot_pool (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  slot_msg_valid,
  input  logic [1:0]            slot_msg_type,
  input  sched_pkg::core_id_t   slot_msg_core,
  input  sched_pkg::slot_t      slot_msg_slot,
  input  sched_pkg::core_mask_t slots_flush,
  input  logic                  desc_pop,
  input  sched_pkg::core_id_t   pop_core,
  output sched_pkg::slot_t      head_slots [`SCHED_CORE_COUNT],
  output sched_pkg::slot_t      slot_counts [`SCHED_CORE_COUNT],
  output logic                  slot_err
);
  import sched_pkg::*;

  localparam int CORES = `SCHED_CORE_COUNT;

  core_mask_t init_v;
  core_mask_t ret_v;
  core_mask_t pop_v;
  core_mask_t head_v;
  core_mask_t enq_err;
  slot_t      slot_r;
  slot_t      head_raw [CORES];

  always_ff @(posedge clk) begin
    slot_r <= slot_msg_slot;
  end

  // Strobes are registered per core, keepers update on the next edge
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_v   <= '0;
      ret_v    <= '0;
      slot_err <= 1'b0;
    end else begin
      for (int c = 0; c < CORES; c++) begin
        init_v[c] <= slot_msg_valid && (slot_msg_type == `SCHED_MSG_INIT) &&
                     (slot_msg_core == core_id_t'(c));
        ret_v[c]  <= slot_msg_valid && (slot_msg_type == `SCHED_MSG_RETURN) &&
                     (slot_msg_core == core_id_t'(c));
      end
      slot_err <= |enq_err;
    end
  end

  for (genvar c = 0; c < CORES; c++) begin : g_core
    assign pop_v[c] = desc_pop && (pop_core == core_id_t'(c));

    slot_keeper u_keeper (
      .clk            (clk),
      .rst_r          (rst_r),
      .flush          (slots_flush[c]),
      .init_valid     (init_v[c]),
      .init_slots     (slot_r),
      .slot_in_valid  (ret_v[c]),
      .slot_in        (slot_r),
      .slot_pop       (pop_v[c]),
      .slot_out       (head_raw[c]),
      .slot_out_valid (head_v[c]),
      .slot_count     (slot_counts[c]),
      .enq_err        (enq_err[c])
    );

    // Empty keeper shows slot 0
    assign head_slots[c] = head_v[c] ? head_raw[c] : '0;
  end

endmodule

// ==== src/core_selector.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module core_selector (
  input  sched_pkg::slot_t      slot_counts [`SCHED_CORE_COUNT],
  input  sched_pkg::core_mask_t income_cores,
  output sched_pkg::core_id_t   sel_core,
  output logic                  sel_valid
);
  import sched_pkg::*;

  localparam int N = `SCHED_CORE_COUNT;

  // Heap-ordered tree, leaves at N-1 and up, root at 0
  logic     node_v   [2*N-1];
  slot_t    node_cnt [2*N-1];
  core_id_t node_id  [2*N-1];

  always_comb begin
    for (int c = 0; c < N; c++) begin
      node_v[N-1+c]   = income_cores[c] && (slot_counts[c] != '0);
      node_cnt[N-1+c] = slot_counts[c];
      node_id[N-1+c]  = core_id_t'(c);
    end
    // Left child holds lower indices, so it keeps a tie
    for (int n = N - 2; n >= 0; n--) begin
      if (node_v[2*n+1] && (!node_v[2*n+2] || node_cnt[2*n+1] >= node_cnt[2*n+2])) begin
        node_v[n]   = node_v[2*n+1];
        node_cnt[n] = node_cnt[2*n+1];
        node_id[n]  = node_id[2*n+1];
      end else begin
        node_v[n]   = node_v[2*n+2];
        node_cnt[n] = node_cnt[2*n+2];
        node_id[n]  = node_id[2*n+2];
      end
    end
  end

  assign sel_core  = node_id[0];
  assign sel_valid = node_v[0];

endmodule

// ==== src/port_dispatcher.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module port_dispatcher (
  input  logic                clk,
  input  logic                rst_r,
  input  sched_pkg::if_mask_t enabled_ints,
  input  sched_pkg::if_mask_t release_desc,
  input  sched_pkg::core_id_t sel_core,
  input  logic                sel_valid,
  input  sched_pkg::slot_t    head_slots [`SCHED_CORE_COUNT],
  input  sched_pkg::data_t    rx_tdata [`SCHED_IF_COUNT],
  input  sched_pkg::if_mask_t rx_tvalid,
  input  sched_pkg::if_mask_t rx_tlast,
  input  sched_pkg::if_mask_t core_tready,
  output logic                desc_pop,
  output sched_pkg::dest_t    port_dest [`SCHED_IF_COUNT],
  output sched_pkg::if_mask_t rx_tready,
  output sched_pkg::data_t    core_tdata [`SCHED_IF_COUNT],
  output sched_pkg::if_mask_t core_tvalid,
  output sched_pkg::if_mask_t core_tlast,
  output sched_pkg::dest_t    core_tdest [`SCHED_IF_COUNT]
);
  import sched_pkg::*;

  localparam int PORTS = `SCHED_IF_COUNT;
  localparam int IDX_W = $clog2(PORTS);

  port_state_e      state [PORTS];
  dest_t            act_dest [PORTS];
  if_mask_t         port_open;
  if_mask_t         port_valid;
  if_mask_t         last_word;
  if_mask_t         desc_req;
  if_mask_t         port_grant;
  logic [IDX_W-1:0] last_ptr;
  logic [IDX_W-1:0] grant_idx;
  logic             req_found;

  always_comb begin
    for (int p = 0; p < PORTS; p++) begin
      port_open[p]  = (state[p] != STALL) && enabled_ints[p];
      // Only idle or running ports without a spare descriptor ask
      desc_req[p]   = enabled_ints[p] && (state[p] == STALL || state[p] == WAIT);
      port_grant[p] = desc_pop && (grant_idx == IDX_W'(p));
      core_tdest[p] = (state[p] == FIRST) ? port_dest[p] : act_dest[p];
    end
  end

  assign rx_tready   = core_tready & port_open;
  assign core_tvalid = rx_tvalid & port_open;
  assign core_tlast  = rx_tlast;
  assign core_tdata  = rx_tdata;
  assign port_valid  = rx_tvalid & rx_tready;
  assign last_word   = port_valid & rx_tlast;

  // Round robin, search starts after the last granted port
  always_comb begin
    req_found = 1'b0;
    grant_idx = last_ptr;
    for (int k = 1; k <= PORTS; k++) begin
      if (!req_found && desc_req[(int'(last_ptr) + k) % PORTS]) begin
        req_found = 1'b1;
        grant_idx = IDX_W'((int'(last_ptr) + k) % PORTS);
      end
    end
  end

  assign desc_pop = req_found && sel_valid;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      last_ptr <= IDX_W'(PORTS - 1);
      for (int p = 0; p < PORTS; p++) begin
        port_dest[p] <= '0;
      end
    end else if (desc_pop) begin
      last_ptr             <= grant_idx;
      port_dest[grant_idx] <= {sel_core, head_slots[sel_core]};
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < PORTS; p++) begin
      if (rst_r) begin
        state[p] <= STALL;
      end else begin
        case (state[p])
          STALL: if (port_grant[p]) state[p] <= FIRST;
          FIRST: begin
            if (last_word[p]) begin
              state[p] <= STALL;
            end else if (port_valid[p]) begin
              state[p] <= WAIT;
            end else if (release_desc[p]) begin
              state[p] <= STALL;
            end
          end
          WAIT: begin
            if (port_grant[p]) begin
              state[p] <= last_word[p] ? FIRST : MID;
            end else if (last_word[p]) begin
              state[p] <= STALL;
            end
          end
          MID: begin
            // A released descriptor is dropped, not used for the next packet
            if (last_word[p]) begin
              state[p] <= release_desc[p] ? STALL : FIRST;
            end else if (release_desc[p]) begin
              state[p] <= WAIT;
            end
          end
          default: state[p] <= STALL;
        endcase
      end
    end
  end

  // Packet keeps the destination seen at its first word
  always_ff @(posedge clk) begin
    for (int p = 0; p < PORTS; p++) begin
      if (state[p] == FIRST && port_valid[p]) begin
        act_dest[p] <= port_dest[p];
      end
    end
  end

endmodule

// ==== src/rx_scheduler.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module rx_scheduler (
  input  logic                  clk,
  input  logic                  rst_r,
  input  sched_pkg::host_word_t host_cmd,
  input  sched_pkg::host_word_t host_cmd_wr_data,
  input  logic                  host_cmd_valid,
  output sched_pkg::host_word_t host_cmd_rd_data,
  input  logic                  slot_msg_valid,
  input  logic [1:0]            slot_msg_type,
  input  sched_pkg::core_id_t   slot_msg_core,
  input  sched_pkg::slot_t      slot_msg_slot,
  output logic                  slot_err,
  input  sched_pkg::data_t      rx_tdata [`SCHED_IF_COUNT],
  input  sched_pkg::if_mask_t   rx_tvalid,
  output sched_pkg::if_mask_t   rx_tready,
  input  sched_pkg::if_mask_t   rx_tlast,
  output sched_pkg::data_t      core_tdata [`SCHED_IF_COUNT],
  output sched_pkg::if_mask_t   core_tvalid,
  input  sched_pkg::if_mask_t   core_tready,
  output sched_pkg::if_mask_t   core_tlast,
  output sched_pkg::dest_t      core_tdest [`SCHED_IF_COUNT]
);
  import sched_pkg::*;

  core_mask_t income_cores;
  core_mask_t slots_flush;
  if_mask_t   enabled_ints;
  if_mask_t   release_desc;
  slot_t      head_slots [`SCHED_CORE_COUNT];
  slot_t      slot_counts [`SCHED_CORE_COUNT];
  dest_t      port_dest [`SCHED_IF_COUNT];
  core_id_t   sel_core;
  logic       sel_valid;
  logic       desc_pop;

  // Enabled cores only gate income and are read back by the host
  host_cmd_regs u_host_cmd_regs (
    .clk              (clk),
    .rst_r            (rst_r),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .slot_counts      (slot_counts),
    .port_dest        (port_dest),
    .income_cores     (income_cores),
    .enabled_cores    (),
    .enabled_ints     (enabled_ints),
    .slots_flush      (slots_flush),
    .release_desc     (release_desc),
    .host_cmd_rd_data (host_cmd_rd_data)
  );

  slot_pool u_slot_pool (
    .clk            (clk),
    .rst_r          (rst_r),
    .slot_msg_valid (slot_msg_valid),
    .slot_msg_type  (slot_msg_type),
    .slot_msg_core  (slot_msg_core),
    .slot_msg_slot  (slot_msg_slot),
    .slots_flush    (slots_flush),
    .desc_pop       (desc_pop),
    .pop_core       (sel_core),
    .head_slots     (head_slots),
    .slot_counts    (slot_counts),
    .slot_err       (slot_err)
  );

  core_selector u_core_selector (
    .slot_counts  (slot_counts),
    .income_cores (income_cores),
    .sel_core     (sel_core),
    .sel_valid    (sel_valid)
  );

  port_dispatcher u_port_dispatcher (
    .clk          (clk),
    .rst_r        (rst_r),
    .enabled_ints (enabled_ints),
    .release_desc (release_desc),
    .sel_core     (sel_core),
    .sel_valid    (sel_valid),
    .head_slots   (head_slots),
    .rx_tdata     (rx_tdata),
    .rx_tvalid    (rx_tvalid),
    .rx_tlast     (rx_tlast),
    .core_tready  (core_tready),
    .desc_pop     (desc_pop),
    .port_dest    (port_dest),
    .rx_tready    (rx_tready),
    .core_tdata   (core_tdata),
    .core_tvalid  (core_tvalid),
    .core_tlast   (core_tlast),
    .core_tdest   (core_tdest)
  );

endmodule

// ==== dv/sched_checker.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module sched_checker (
  input  logic                  clk,
  input  logic                  row_start,
  input  logic                  row_end,
  input  logic [127:0]          name,
  input  logic                  chk_dp,
  input  logic                  exp_rdy,
  input  logic                  exp_cv,
  input  sched_pkg::data_t      exp_data,
  input  logic                  exp_last,
  input  logic                  chk_dest,
  input  sched_pkg::dest_t      exp_dest,
  input  logic                  chk_rd,
  input  sched_pkg::host_word_t exp_rd,
  input  logic                  exp_err,
  input  logic                  exp_stall,
  input  sched_pkg::if_mask_t   rx_tready,
  input  sched_pkg::if_mask_t   core_tvalid,
  input  sched_pkg::data_t      core_tdata0,
  input  logic                  core_tlast0,
  input  sched_pkg::dest_t      core_tdest0,
  input  sched_pkg::host_word_t host_cmd_rd_data,
  input  logic                  slot_err,
  output int                    tests,
  output int                    errors
);
  import sched_pkg::*;

  logic err_seen;
  logic row_bad;

  initial begin
    tests    = 0;
    errors   = 0;
    err_seen = 1'b0;
    row_bad  = 1'b0;
  end

  always @(negedge clk) begin
    if (row_start) begin
      err_seen = 1'b0;
      row_bad  = 1'b0;
      if (chk_dp) begin
        if (rx_tready[0] !== exp_rdy) begin
          $display("ERR %0s rx_tready expected %0b actual %0b", name, exp_rdy, rx_tready[0]);
          row_bad = 1'b1;
        end
        if (core_tvalid[0] === 1'b1 && !exp_cv) begin
          $display("Unexpected valid on core port 0 in test %0s", name);
          row_bad = 1'b1;
        end else if (core_tvalid[0] !== exp_cv) begin
          $display("ERR %0s core_tvalid expected %0b actual %0b", name, exp_cv, core_tvalid[0]);
          row_bad = 1'b1;
        end
        if (exp_cv && core_tdata0 !== exp_data) begin
          $display("ERR %0s core_tdata expected %h actual %h", name, exp_data, core_tdata0);
          row_bad = 1'b1;
        end
        if (exp_cv && core_tlast0 !== exp_last) begin
          $display("ERR %0s core_tlast expected %0b actual %0b", name, exp_last, core_tlast0);
          row_bad = 1'b1;
        end
      end
      if (chk_dest && core_tdest0 !== exp_dest) begin
        $display("ERR %0s core_tdest expected %h actual %h", name, exp_dest, core_tdest0);
        row_bad = 1'b1;
      end
    end
    if (slot_err === 1'b1) begin
      err_seen = 1'b1;
    end
    // Port 1 never receives traffic
    if (core_tvalid[1] !== 1'b0) begin
      $display("Unexpected valid on core port 1 during test %0s", name);
      row_bad = 1'b1;
    end
    if (row_end) begin
      if (chk_rd && host_cmd_rd_data !== exp_rd) begin
        $display("ERR %0s read data expected %h actual %h", name, exp_rd, host_cmd_rd_data);
        row_bad = 1'b1;
      end
      // Released port sits in STALL until the next grant
      if (exp_stall && rx_tready[0] !== 1'b0) begin
        $display("ERR %0s rx_tready after release expected 0 actual %0b", name, rx_tready[0]);
        row_bad = 1'b1;
      end
      if (exp_err && !err_seen) begin
        $display("Slot error did not pulse in test %0s", name);
        row_bad = 1'b1;
      end else if (!exp_err && err_seen) begin
        $display("Slot error pulsed without cause in test %0s", name);
        row_bad = 1'b1;
      end
      tests = tests + 1;
      if (row_bad) begin
        errors = errors + 1;
        $display("%0s: failed", name);
      end else begin
        $display("%0s: ok", name);
      end
    end
  end

endmodule

// ==== dv/tb_rx_scheduler.sv ====
`timescale 1ns/1ps
`include "sched_config.svh"

module tb_rx_scheduler;
  import sched_pkg::*;

  localparam int ROWS = 22;

  typedef struct packed {
    logic [127:0] name;
    logic         wr;
    logic [2:0]   addr;
    logic [1:0]   low;
    logic [31:0]  wdata;
    logic         smsg;
    logic [1:0]   stype;
    logic [1:0]   score;
    logic [3:0]   sslot;
    logic         rxv;
    logic         rxl;
    logic         crdy;
    logic         new_data;
    logic         chk_dp;
    logic         exp_rdy;
    logic         exp_cv;
    logic         chk_dest;
    logic [5:0]   exp_dest;
    logic         chk_rd;
    logic [31:0]  exp_rd;
    logic         exp_err;
    logic         exp_stall;
  } row_t;

  logic       clk;
  logic       rst_r;
  host_word_t host_cmd;
  host_word_t host_cmd_wr_data;
  logic       host_cmd_valid;
  host_word_t host_cmd_rd_data;
  logic       slot_msg_valid;
  logic [1:0] slot_msg_type;
  core_id_t   slot_msg_core;
  slot_t      slot_msg_slot;
  logic       slot_err;
  data_t      rx_tdata [`SCHED_IF_COUNT];
  if_mask_t   rx_tvalid;
  if_mask_t   rx_tready;
  if_mask_t   rx_tlast;
  data_t      core_tdata [`SCHED_IF_COUNT];
  if_mask_t   core_tvalid;
  if_mask_t   core_tready;
  if_mask_t   core_tlast;
  dest_t      core_tdest [`SCHED_IF_COUNT];

  row_t  rows [ROWS];
  row_t  cur;
  data_t exp_word;
  logic  row_start;
  logic  row_end;
  int    tests;
  int    errors;

  rx_scheduler dut (
    .clk (clk), .rst_r (rst_r),
    .host_cmd (host_cmd), .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid (host_cmd_valid), .host_cmd_rd_data (host_cmd_rd_data),
    .slot_msg_valid (slot_msg_valid), .slot_msg_type (slot_msg_type),
    .slot_msg_core (slot_msg_core), .slot_msg_slot (slot_msg_slot),
    .slot_err (slot_err),
    .rx_tdata (rx_tdata), .rx_tvalid (rx_tvalid), .rx_tready (rx_tready),
    .rx_tlast (rx_tlast),
    .core_tdata (core_tdata), .core_tvalid (core_tvalid), .core_tready (core_tready),
    .core_tlast (core_tlast), .core_tdest (core_tdest)
  );

  sched_checker u_checker (
    .clk (clk), .row_start (row_start), .row_end (row_end), .name (cur.name),
    .chk_dp (cur.chk_dp), .exp_rdy (cur.exp_rdy), .exp_cv (cur.exp_cv),
    .exp_data (exp_word), .exp_last (cur.rxl),
    .chk_dest (cur.chk_dest), .exp_dest (cur.exp_dest),
    .chk_rd (cur.chk_rd), .exp_rd (cur.exp_rd), .exp_err (cur.exp_err),
    .exp_stall (cur.exp_stall),
    .rx_tready (rx_tready), .core_tvalid (core_tvalid), .core_tdata0 (core_tdata[0]),
    .core_tlast0 (core_tlast[0]),
    .core_tdest0 (core_tdest[0]), .host_cmd_rd_data (host_cmd_rd_data),
    .slot_err (slot_err), .tests (tests), .errors (errors)
  );

  always #2 clk = ~clk;

  // Rows: name, host wr/addr/low/data, slot msg, rx fields, datapath, dest, read, slot_err, stall
  task automatic fill_table();
    rows[0]  = '{"income_early", 1, `SCHED_ADDR_INCOME, 0, 32'hF, 0, 0, 0, 0,
                 1, 0, 1, 1, 1, 0, 0, 0, 6'h0, 1, 32'h0, 0, 0};
    rows[1]  = '{"enable_wr", 1, `SCHED_ADDR_ENABLE, 0, 32'h6, 0, 0, 0, 0,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, 32'h6, 0, 0};
    rows[2]  = '{"income_wr", 1, `SCHED_ADDR_INCOME, 0, 32'hF, 0, 0, 0, 0,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, 32'h6, 0, 0};
    rows[3]  = '{"income_read", 0, `SCHED_ADDR_INCOME, 0, 32'h0, 0, 0, 0, 0,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, 32'h6, 0, 0};
    rows[4]  = '{"bad_addr", 0, 3'd7, 0, 32'h0, 0, 0, 0, 0,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, `SCHED_BAD_READ, 0, 0};
    rows[5]  = '{"init_core1", 0, `SCHED_ADDR_COUNT, 1, 32'h0, 1, `SCHED_MSG_INIT, 1, 5,
                 1, 0, 1, 1, 1, 0, 0, 0, 6'h0, 1, 32'd5, 0, 0};
    rows[6]  = '{"init_core2", 0, `SCHED_ADDR_COUNT, 2, 32'h0, 1, `SCHED_MSG_INIT, 2, 3,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, 32'd3, 0, 0};
    rows[7]  = '{"ints_wr", 1, `SCHED_ADDR_INTS, 0, 32'h1, 0, 0, 0, 0,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, 32'h1, 0, 0};
    rows[8]  = '{"grant_count", 0, `SCHED_ADDR_COUNT, 1, 32'h0, 0, 0, 0, 0,
                 0, 0, 1, 0, 1, 1, 0, 1, {2'd1, 4'd1}, 1, 32'd4, 0, 0};
    rows[9]  = '{"pkt1_first", 0, `SCHED_ADDR_COUNT, 1, 32'h0, 0, 0, 0, 0,
                 1, 0, 1, 1, 1, 1, 1, 1, {2'd1, 4'd1}, 1, 32'd3, 0, 0};
    rows[10] = '{"pkt1_last", 0, `SCHED_ADDR_COUNT, 1, 32'h0, 0, 0, 0, 0,
                 1, 1, 1, 1, 1, 1, 1, 1, {2'd1, 4'd1}, 1, 32'd3, 0, 0};
    rows[11] = '{"pkt2_dest", 0, `SCHED_ADDR_COUNT, 2, 32'h0, 0, 0, 0, 0,
                 0, 0, 1, 0, 1, 1, 0, 1, {2'd1, 4'd2}, 1, 32'd3, 0, 0};
    rows[12] = '{"backpressure", 0, `SCHED_ADDR_COUNT, 1, 32'h0, 0, 0, 0, 0,
                 1, 0, 0, 1, 1, 0, 1, 1, {2'd1, 4'd2}, 1, 32'd3, 0, 0};
    rows[13] = '{"bp_release", 0, `SCHED_ADDR_COUNT, 1, 32'h0, 0, 0, 0, 0,
                 1, 1, 1, 0, 1, 1, 1, 1, {2'd1, 4'd2}, 1, 32'd2, 0, 0};
    rows[14] = '{"init_full", 0, `SCHED_ADDR_COUNT, 3, 32'h0, 1, `SCHED_MSG_INIT, 3, 8,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, 32'd8, 0, 0};
    rows[15] = '{"return_full", 0, `SCHED_ADDR_COUNT, 3, 32'h0, 1, `SCHED_MSG_RETURN, 3, 5,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, 32'd8, 1, 0};
    rows[16] = '{"flush_core1", 1, `SCHED_ADDR_FLUSH, 0, 32'h2, 0, 0, 0, 0,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 0, 32'h0, 0, 0};
    rows[17] = '{"flush_count", 0, `SCHED_ADDR_COUNT, 1, 32'h0, 0, 0, 0, 0,
                 0, 0, 1, 0, 1, 1, 0, 1, {2'd1, 4'd3}, 1, 32'd0, 0, 0};
    rows[18] = '{"release_idle", 1, `SCHED_ADDR_RELEASE, 0, 32'h1, 0, 0, 0, 0,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, `SCHED_BAD_READ, 0, 1};
    rows[19] = '{"release_dest", 0, `SCHED_ADDR_COUNT, 2, 32'h0, 0, 0, 0, 0,
                 0, 0, 1, 0, 1, 1, 0, 1, {2'd2, 4'd1}, 1, 32'd2, 0, 0};
    rows[20] = '{"ints_off", 1, `SCHED_ADDR_INTS, 0, 32'h0, 0, 0, 0, 0,
                 0, 0, 1, 0, 0, 0, 0, 0, 6'h0, 1, 32'h0, 0, 0};
    rows[21] = '{"port_disabled", 0, `SCHED_ADDR_INCOME, 0, 32'h0, 0, 0, 0, 0,
                 1, 0, 1, 1, 1, 0, 0, 0, 6'h0, 1, 32'h6, 0, 0};
  endtask

  task automatic apply_row(input row_t r);
    data_t word;
    host_cmd         <= {r.wr, 1'b1, r.addr, 25'd0, r.low};
    host_cmd_wr_data <= r.wdata;
    host_cmd_valid   <= r.wr;
    slot_msg_valid   <= r.smsg;
    slot_msg_type    <= r.stype;
    slot_msg_core    <= r.score;
    slot_msg_slot    <= r.sslot;
    rx_tvalid[0]     <= r.rxv;
    rx_tlast[0]      <= r.rxl;
    core_tready[0]   <= r.crdy;
    if (r.new_data) begin
      word = $urandom;
      rx_tdata[0] <= word;
      exp_word    <= word;
    end
  endtask

  initial begin
    void'($urandom(32'h6e8ada87));
    clk              = 1'b0;
    rst_r            = 1'b1;
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    slot_msg_valid   = 1'b0;
    slot_msg_type    = '0;
    slot_msg_core    = '0;
    slot_msg_slot    = '0;
    rx_tdata[0]      = '0;
    rx_tdata[1]      = '0;
    rx_tvalid        = '0;
    rx_tlast         = '0;
    core_tready      = '0;
    exp_word         = '0;
    row_start        = 1'b0;
    row_end          = 1'b0;
    cur              = '0;
    fill_table();
    repeat (2) @(posedge clk);
    rst_r <= 1'b0;
    for (int i = 0; i < ROWS; i++) begin
      @(posedge clk);
      apply_row(rows[i]);
      cur       <= rows[i];
      row_start <= 1'b1;
      row_end   <= 1'b0;
      @(posedge clk);
      // Strobes and data words last one cycle
      host_cmd_valid <= 1'b0;
      slot_msg_valid <= 1'b0;
      rx_tvalid[0]   <= 1'b0;
      row_start      <= 1'b0;
      repeat (2) @(posedge clk);
      row_end <= 1'b1;
    end
    @(posedge clk);
    row_end <= 1'b0;
    @(negedge clk);
    $display("Tests run %0d, tests failed %0d", tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Each row takes four cycles, allow five times that
  initial begin
    repeat (ROWS * 20) @(posedge clk);
    $display("Timeout, the test table did not finish in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+src
src/sched_pkg.sv
src/host_cmd_regs.sv
src/slot_keeper.sv
src/slot_pool.sv
src/core_selector.sv
src/port_dispatcher.sv
src/rx_scheduler.sv
dv/sched_checker.sv
dv/tb_rx_scheduler.sv

// ==== Bender.yml ====
package:
  name: rx_scheduler

export_include_dirs:
  - src

sources:
  - files:
      - src/sched_pkg.sv
      - src/host_cmd_regs.sv
      - src/slot_keeper.sv
      - src/slot_pool.sv
      - src/core_selector.sv
      - src/port_dispatcher.sv
      - src/rx_scheduler.sv
  - target: test
    files:
      - dv/sched_checker.sv
      - dv/tb_rx_scheduler.sv
